/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcode from instruction bits 6:2
    typedef enum logic [4:0] {
        load     = 5'b00000,
        misc_mem = 5'b00011,
        op_imm   = 5'b00100,
        auipc    = 5'b00101,
        store    = 5'b01000,
        op       = 5'b01100,
        lui      = 5'b01101,
        branch   = 5'b11000,
        jalr     = 5'b11001,
        jal      = 5'b11011,
        system   = 5'b11100
    } opcode_t;

    // funct3 for op and op_imm
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op
    } alu_op_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  funct3;
        // funct7 bit 5 which selects sub and sra
        logic        alt;
        word_t       imm;
    } decoded_instr_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } alu_flags_t;

endpackage

/* source/wb_pkg.sv */
package wb_pkg;

    // matches the low two bits of load and store funct3
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } bus_size_t;

    // one transfer as requested by the sequencer
    typedef struct packed {
        rv_isa_pkg::word_t addr;
        rv_isa_pkg::word_t wdata;
        bus_size_t         size;
        logic              we;
        logic              unsigned_load;
    } bus_cmd_t;

    // wishbone master outputs
    typedef struct packed {
        rv_isa_pkg::word_t adr;
        rv_isa_pkg::word_t dat;
        logic [3:0]        sel;
        logic              we;
        logic              cyc;
        logic              stb;
    } wb_req_t;

    // wishbone master inputs
    typedef struct packed {
        rv_isa_pkg::word_t dat;
        logic              ack;
    } wb_rsp_t;

endpackage

/* source/rv_decoder.sv */
module rv_decoder (
    input  logic                       clk,
    input  logic                       decode_en,
    input  rv_isa_pkg::word_t          instr,
    output rv_isa_pkg::decoded_instr_t dec
);
    import rv_isa_pkg::*;

    opcode_t opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    word_t   imm;

    assign opcode = opcode_t'(instr[6:2]);

    // immediate formats sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            store:       imm = imm_s;
            branch:      imm = imm_b;
            lui, auipc:  imm = imm_u;
            jal:         imm = imm_j;
            default:     imm = imm_i;
        endcase
    end

    // held for the rest of the instruction
    always_ff @(posedge clk) begin
        if (decode_en) begin
            dec.opcode <= opcode;
            dec.rd     <= instr[11:7];
            dec.rs1    <= instr[19:15];
            dec.rs2    <= instr[24:20];
            dec.funct3 <= instr[14:12];
            dec.alt    <= instr[30];
            dec.imm    <= imm;
        end
    end

endmodule

/* source/register_file.sv */
module register_file (
    input  logic                 clk,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::word_t    rs1_val,
    output rv_isa_pkg::word_t    rs2_val,
    input  logic                 we,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::word_t    wdata
);
    import rv_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_comb begin
        rs1_val = (rs1 == '0) ? '0 : regs[rs1];
        rs2_val = (rs2 == '0) ? '0 : regs[rs2];
    end

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* source/rv_alu.sv */
module rv_alu (
    input  rv_isa_pkg::alu_op_t    op,
    input  rv_isa_pkg::word_t      a,
    input  rv_isa_pkg::word_t      b,
    output rv_isa_pkg::word_t      result,
    output rv_isa_pkg::alu_flags_t flags
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compare flags always valid for the branch decision
    always_comb begin
        flags.eq  = (a == b);
        flags.lt  = ($signed(a) < $signed(b));
        flags.ltu = (a < b);
    end

    always_comb begin
        case (op)
            add:     result = a + b;
            sub:     result = a - b;
            sll:     result = a << shamt;
            slt:     result = {{(xlen - 1){1'b0}}, flags.lt};
            sltu:    result = {{(xlen - 1){1'b0}}, flags.ltu};
            xor_op:  result = a ^ b;
            srl:     result = a >> shamt;
            sra:     result = $signed(a) >>> shamt;
            or_op:   result = a | b;
            and_op:  result = a & b;
            default: result = a + b;
        endcase
    end

endmodule

/* source/wb_master.sv */
module wb_master (
    input  logic              clk,
    input  logic              reset,
    input  wb_pkg::bus_cmd_t  cmd,
    input  logic              start,
    output logic              done,
    output rv_isa_pkg::word_t rdata,
    output wb_pkg::wb_req_t   wb_req,
    input  wb_pkg::wb_rsp_t   wb_rsp
);
    import rv_isa_pkg::*;
    import wb_pkg::*;

    bus_cmd_t   cmd_q;
    logic       active;
    logic [3:0] lane_sel;
    word_t      lane_data;
    word_t      shifted;
    word_t      load_word;

    // byte lanes for the latched access
    always_comb begin
        case (cmd_q.size)
            size_byte: lane_sel = 4'b0001 << cmd_q.addr[1:0];
            size_half: lane_sel = cmd_q.addr[1] ? 4'b1100 : 4'b0011;
            default:   lane_sel = 4'b1111;
        endcase
    end

    // store data copied onto every lane it could land on
    always_comb begin
        case (cmd_q.size)
            size_byte: lane_data = {4{cmd_q.wdata[7:0]}};
            size_half: lane_data = {2{cmd_q.wdata[15:0]}};
            default:   lane_data = cmd_q.wdata;
        endcase
    end

    // addressed lane moved down and then extended
    assign shifted = wb_rsp.dat >> {cmd_q.addr[1:0], 3'b000};

    always_comb begin
        case (cmd_q.size)
            size_byte: load_word = {{24{shifted[7] & ~cmd_q.unsigned_load}}, shifted[7:0]};
            size_half: load_word = {{16{shifted[15] & ~cmd_q.unsigned_load}}, shifted[15:0]};
            default:   load_word = shifted;
        endcase
    end

    // word address on adr with the lanes carried by sel
    always_comb begin
        wb_req.adr = {cmd_q.addr[31:2], 2'b00};
        wb_req.dat = lane_data;
        wb_req.sel = lane_sel;
        wb_req.we  = active && cmd_q.we;
        wb_req.cyc = active;
        wb_req.stb = active;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= active && wb_rsp.ack;
            if (active) begin
                if (wb_rsp.ack) begin
                    active <= 1'b0;
                end
            end else if (start) begin
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !active) begin
            cmd_q <= cmd;
        end
        if (active && wb_rsp.ack) begin
            rdata <= load_word;
        end
    end

endmodule

/* source/rv_sequencer.sv */
module rv_sequencer #(
    parameter rv_isa_pkg::word_t reset_vector = '0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  rv_isa_pkg::word_t          instr_word,
    output logic                       decode_en,
    input  rv_isa_pkg::decoded_instr_t dec,
    input  rv_isa_pkg::word_t          rs1_val,
    input  rv_isa_pkg::word_t          rs2_val,
    output logic                       reg_we,
    output rv_isa_pkg::reg_idx_t       reg_waddr,
    output rv_isa_pkg::word_t          reg_wdata,
    output rv_isa_pkg::alu_op_t        alu_op,
    output rv_isa_pkg::word_t          alu_a,
    output rv_isa_pkg::word_t          alu_b,
    input  rv_isa_pkg::word_t          alu_result,
    input  rv_isa_pkg::alu_flags_t     alu_flags,
    output wb_pkg::bus_cmd_t           bus_cmd,
    output logic                       bus_start,
    input  logic                       bus_done,
    input  rv_isa_pkg::word_t          bus_rdata
);
    import rv_isa_pkg::*;
    import wb_pkg::*;

    typedef enum logic [2:0] {
        s_fetch,
        s_fetch_wait,
        s_decode,
        s_execute,
        s_mem_wait
    } state_t;

    state_t state;
    word_t  pc;
    logic   full_width;
    logic   alu_wb;
    logic   mem_op;
    logic   taken;
    word_t  target;
    word_t  next_pc;

    // funct3 and alt bit to an alu operation
    function automatic alu_op_t arith_op(input logic [2:0] funct3, input logic alt,
                                         input logic reg_form);
        alu_op_t sel;
        case (funct3)
            f3_add:  sel = (alt && reg_form) ? sub : add;
            f3_sll:  sel = sll;
            f3_slt:  sel = slt;
            f3_sltu: sel = sltu;
            f3_xor:  sel = xor_op;
            f3_sr:   sel = alt ? sra : srl;
            f3_or:   sel = or_op;
            default: sel = and_op;
        endcase
        return sel;
    endfunction

    // operand selection where loads and stores use rs1 + imm
    always_comb begin
        alu_op = add;
        alu_a  = rs1_val;
        alu_b  = dec.imm;
        alu_wb = 1'b0;
        case (dec.opcode)
            op: begin
                alu_op = arith_op(dec.funct3, dec.alt, 1'b1);
                alu_b  = rs2_val;
                alu_wb = 1'b1;
            end
            op_imm: begin
                alu_op = arith_op(dec.funct3, dec.alt, 1'b0);
                alu_wb = 1'b1;
            end
            lui: begin
                alu_a  = '0;
                alu_wb = 1'b1;
            end
            auipc: begin
                alu_a  = pc;
                alu_wb = 1'b1;
            end
            // link value pc + 4
            jal, jalr: begin
                alu_a  = pc;
                alu_b  = 32'd4;
                alu_wb = 1'b1;
            end
            branch:  alu_b = rs2_val;
            default: alu_op = add;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            f3_beq:  taken = alu_flags.eq;
            f3_bne:  taken = !alu_flags.eq;
            f3_blt:  taken = alu_flags.lt;
            f3_bge:  taken = !alu_flags.lt;
            f3_bltu: taken = alu_flags.ltu;
            f3_bgeu: taken = !alu_flags.ltu;
            default: taken = 1'b0;
        endcase
    end

    assign mem_op = full_width && (dec.opcode == load || dec.opcode == store);
    assign target = ((dec.opcode == jalr) ? rs1_val : pc) + dec.imm;

    // a 16-bit encoding just falls through to pc + 4
    always_comb begin
        next_pc = pc + 32'd4;
        if (full_width) begin
            case (dec.opcode)
                jal:     next_pc = target;
                jalr:    next_pc = {target[31:1], 1'b0};
                branch:  next_pc = taken ? target : pc + 32'd4;
                default: next_pc = pc + 32'd4;
            endcase
        end
    end

    always_comb begin
        if (state == s_fetch) begin
            bus_cmd.addr          = pc;
            bus_cmd.wdata         = '0;
            bus_cmd.size          = size_word;
            bus_cmd.we            = 1'b0;
            bus_cmd.unsigned_load = 1'b0;
        end else begin
            bus_cmd.addr          = alu_result;
            bus_cmd.wdata         = rs2_val;
            bus_cmd.size          = (dec.funct3[1:0] == 2'b00) ? size_byte :
                                    (dec.funct3[1:0] == 2'b01) ? size_half : size_word;
            bus_cmd.we            = (dec.opcode == store);
            bus_cmd.unsigned_load = dec.funct3[2];
        end
    end

    assign bus_start = (state == s_fetch) || (state == s_execute && mem_op);
    assign decode_en = (state == s_decode);

    // alu results retire in execute and loads when the bus returns
    assign reg_waddr = dec.rd;
    assign reg_wdata = (state == s_mem_wait) ? bus_rdata : alu_result;
    assign reg_we    = (state == s_execute && alu_wb && full_width) ||
                       (state == s_mem_wait && bus_done && dec.opcode == load);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= s_fetch;
            pc         <= reset_vector;
            full_width <= 1'b0;
        end else begin
            case (state)
                s_fetch: state <= s_fetch_wait;
                s_fetch_wait: begin
                    if (bus_done) begin
                        state <= s_decode;
                    end
                end
                s_decode: begin
                    full_width <= (instr_word[1:0] == 2'b11);
                    state      <= s_execute;
                end
                s_execute: begin
                    pc    <= next_pc;
                    state <= mem_op ? s_mem_wait : s_fetch;
                end
                s_mem_wait: begin
                    if (bus_done) begin
                        state <= s_fetch;
                    end
                end
                default: state <= s_fetch;
            endcase
        end
    end

endmodule

/* source/rv_core.sv */
module rv_core #(
    parameter rv_isa_pkg::word_t reset_vector = '0
) (
    input  logic            clk,
    input  logic            reset,
    output wb_pkg::wb_req_t wb_req,
    input  wb_pkg::wb_rsp_t wb_rsp
);
    import rv_isa_pkg::*;
    import wb_pkg::*;

    logic           decode_en;
    decoded_instr_t dec;
    word_t          rs1_val;
    word_t          rs2_val;
    logic           reg_we;
    reg_idx_t       reg_waddr;
    word_t          reg_wdata;
    alu_op_t        alu_op;
    word_t          alu_a;
    word_t          alu_b;
    word_t          alu_result;
    alu_flags_t     alu_flags;
    bus_cmd_t       bus_cmd;
    logic           bus_start;
    logic           bus_done;
    word_t          bus_rdata;

    rv_sequencer #(
        .reset_vector(reset_vector)
    ) i_sequencer (
        .clk        (clk),
        .reset      (reset),
        .instr_word (bus_rdata),
        .decode_en  (decode_en),
        .dec        (dec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .reg_we     (reg_we),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .bus_cmd    (bus_cmd),
        .bus_start  (bus_start),
        .bus_done   (bus_done),
        .bus_rdata  (bus_rdata)
    );

    // fetched word comes straight from the bus read register
    rv_decoder i_decoder (
        .clk       (clk),
        .decode_en (decode_en),
        .instr     (bus_rdata),
        .dec       (dec)
    );

    register_file i_register_file (
        .clk     (clk),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (reg_we),
        .waddr   (reg_waddr),
        .wdata   (reg_wdata)
    );

    rv_alu i_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .flags  (alu_flags)
    );

    wb_master i_wb_master (
        .clk    (clk),
        .reset  (reset),
        .cmd    (bus_cmd),
        .start  (bus_start),
        .done   (bus_done),
        .rdata  (bus_rdata),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

endmodule

/* bench/rv_core_model.svh */
`ifndef rv_core_model_svh
`define rv_core_model_svh

// architectural state of the instruction-level model
word_t      model_mem [0:mem_words-1];
word_t      model_x [0:31];
word_t      model_pc;

// data transfer expected from the last stepped instruction
logic       exp_mem;
logic       exp_we;
word_t      exp_adr;
word_t      exp_dat;
logic [3:0] exp_sel;

function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// executes the instruction at model_pc
task automatic step_model();
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      res;
    word_t      addr;
    word_t      lane;
    word_t      nxt;
    logic       wr;
    logic [2:0] f3;
    int         k;
    ins     = model_mem[model_pc[13:2]];
    f3      = ins[14:12];
    a       = model_x[ins[19:15]];
    b       = model_x[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    nxt     = model_pc + 4;
    res     = '0;
    wr      = 1'b1;
    exp_mem = 1'b0;
    exp_we  = 1'b0;
    case (ins[6:0])
        opc_op:     res = alu_model(f3, ins[30], a, b);
        opc_op_imm: res = alu_model(f3, ins[30] && f3 == 3'd5, a, imm_i);
        opc_lui:    res = {ins[31:12], 12'b0};
        opc_auipc:  res = model_pc + {ins[31:12], 12'b0};
        opc_jal: begin
            res = model_pc + 4;
            nxt = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        opc_jalr: begin
            res = model_pc + 4;
            nxt = (a + imm_i) & ~32'd1;
        end
        opc_branch: begin
            wr = 1'b0;
            if (branch_taken(f3, a, b)) begin
                nxt = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        end
        opc_load, opc_store: begin
            wr      = (ins[6:0] == opc_load);
            exp_mem = 1'b1;
            exp_we  = !wr;
            addr    = a + (wr ? imm_i : {{20{ins[31]}}, ins[31:25], ins[11:7]});
            exp_adr = {addr[31:2], 2'b00};
            case (f3[1:0])
                2'd0: begin
                    exp_sel = 4'b0001 << addr[1:0];
                    exp_dat = {4{b[7:0]}};
                end
                2'd1: begin
                    exp_sel = 4'b0011 << addr[1:0];
                    exp_dat = {2{b[15:0]}};
                end
                default: begin
                    exp_sel = 4'b1111;
                    exp_dat = b;
                end
            endcase
            lane = model_mem[addr[13:2]] >> (8 * addr[1:0]);
            case (f3)
                3'd0: res = {{24{lane[7]}}, lane[7:0]};
                3'd1: res = {{16{lane[15]}}, lane[15:0]};
                3'd4: res = {24'b0, lane[7:0]};
                3'd5: res = {16'b0, lane[15:0]};
                default: res = lane;
            endcase
            if (exp_we) begin
                for (k = 0; k < 4; k++) begin
                    if (exp_sel[k]) begin
                        model_mem[addr[13:2]][8*k +: 8] = exp_dat[8*k +: 8];
                    end
                end
            end
        end
        default: wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
        model_x[ins[11:7]] = res;
    end
    model_pc = nxt;
endtask

`endif

/* bench/rv_core_tb.sv */
module rv_core_tb;
    import rv_isa_pkg::*;
    import wb_pkg::*;

    localparam int    mem_words      = 4096;
    localparam int    prologue_len   = 62;
    localparam int    body_len       = 200;
    localparam int    dump_len       = 32;
    localparam word_t end_pc         = (prologue_len + body_len + dump_len) * 4;
    localparam word_t data_base      = 32'h2000;
    localparam int    dump_offset    = 12'h400;
    localparam int    timeout_cycles = 1000;

    localparam logic [6:0] opc_op     = 7'h33;
    localparam logic [6:0] opc_op_imm = 7'h13;
    localparam logic [6:0] opc_lui    = 7'h37;
    localparam logic [6:0] opc_auipc  = 7'h17;
    localparam logic [6:0] opc_jal    = 7'h6f;
    localparam logic [6:0] opc_jalr   = 7'h67;
    localparam logic [6:0] opc_branch = 7'h63;
    localparam logic [6:0] opc_load   = 7'h03;
    localparam logic [6:0] opc_store  = 7'h23;

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    word_t   mem [0:mem_words-1];
    int      seed;
    int      ack_wait;
    int      prog_idx;

    `include "rv_core_model.svh"

    rv_core i_dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #20 clk = ~clk;

    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    task automatic append_instr(input word_t ins);
        mem[prog_idx] = ins;
        prog_idx++;
    endtask

    // x30 holds the code base for jalr and x31 the data region base
    task automatic build_program();
        int          i;
        int          k;
        word_t       r;
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_idx_t    rd;
        for (i = 0; i < mem_words; i++) begin
            mem[i] = i * 32'h9e3779b1;
        end
        for (i = 0; i < 64; i++) begin
            mem[data_base[13:2] + i] = $random(seed);
        end
        prog_idx = 0;
        for (i = 1; i < 32; i++) begin
            r = $random(seed);
            if (i == 30) begin
                r = '0;
            end
            if (i == 31) begin
                r = {data_base[31:12], 12'b0};
            end
            append_instr(u_type(r[31:12], 5'(i), opc_lui));
            append_instr(i_type(r[11:0], 5'(i), 3'd0, 5'(i), opc_op_imm));
        end
        for (i = 0; i < body_len; i++) begin
            r  = $random(seed);
            f3 = r[14:12];
            rd = 5'(random_below(30));
            // forward offsets only and never past the body
            k  = 1 + random_below(4);
            if (i + k > body_len) begin
                k = body_len - i;
            end
            case (random_below(9))
                0: append_instr(r_type({1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0},
                                       r[24:20], r[19:15], f3, rd));
                1: begin
                    imm = r[31:20];
                    if (f3 == 3'd1) begin
                        imm[11:5] = 7'b0;
                    end
                    if (f3 == 3'd5) begin
                        imm[11:5] = {1'b0, r[30], 5'b0};
                    end
                    append_instr(i_type(imm, r[19:15], f3, rd, opc_op_imm));
                end
                2: append_instr(u_type(r[31:12], rd, opc_lui));
                3: append_instr(u_type(r[31:12], rd, opc_auipc));
                4: begin
                    if (f3 == 3'd2 || f3 == 3'd3) begin
                        f3 = 3'd0;
                    end
                    append_instr(b_type(13'(k * 4), r[24:20], r[19:15], f3));
                end
                5: append_instr(j_type(21'(k * 4), rd));
                // odd target exercises the cleared bit 0
                6: append_instr(i_type(12'((prologue_len + i + k) * 4 + r[0]), 5'd30, 3'd0,
                                       rd, opc_jalr));
                7: begin
                    if (f3[1:0] == 2'b11 || f3 == 3'd6) begin
                        f3 = 3'd2;
                    end
                    imm = 12'(random_below(256)) & ~12'((1 << f3[1:0]) - 1);
                    append_instr(i_type(imm, 5'd31, f3, rd, opc_load));
                end
                default: begin
                    f3  = 3'(random_below(3));
                    imm = 12'(random_below(256)) & ~12'((1 << f3[1:0]) - 1);
                    append_instr(s_type(imm, r[24:20], 5'd31, f3));
                end
            endcase
        end
        // register dump
        for (i = 0; i < dump_len; i++) begin
            append_instr(s_type(12'(dump_offset + 4 * i), 5'(i), 5'd31, 3'd2));
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [71:0] got,
                               input logic [71:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("[FAIL] %s: got %0h, expected %0h", name, got, expected));
        end
    endtask

    // one complete transfer sampled at falling edges
    task automatic wait_transfer(output wb_req_t seen);
        int cycles;
        cycles = 0;
        while (!(wb_req.cyc && wb_req.stb)) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("timeout: the core stopped fetching, no bus cycle in 1000 cycles");
            end
        end
        seen   = wb_req;
        cycles = 0;
        while (!wb_rsp.ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("timeout: the core stopped fetching, no acknowledge in 1000 cycles");
            end
            check_value("wb_req held during wait", wb_req, seen);
        end
        @(negedge clk);
        check_value("wb_req.cyc after ack", wb_req.cyc, 1'b0);
        check_value("wb_req.stb after ack", wb_req.stb, 1'b0);
    endtask

    // memory model with 0 to 3 wait cycles per transfer
    always @(posedge clk) begin
        int byte_lane;
        if (reset) begin
            wb_rsp   <= '0;
            ack_wait = -1;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
            ack_wait   = -1;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (ack_wait < 0) begin
                ack_wait = random_below(4);
            end
            if (ack_wait == 0) begin
                wb_rsp.ack <= 1'b1;
                if (wb_req.we) begin
                    for (byte_lane = 0; byte_lane < 4; byte_lane++) begin
                        if (wb_req.sel[byte_lane]) begin
                            mem[wb_req.adr[13:2]][8*byte_lane +: 8] =
                                wb_req.dat[8*byte_lane +: 8];
                        end
                    end
                end else begin
                    wb_rsp.dat <= mem[wb_req.adr[13:2]];
                end
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    initial begin
        wb_req_t seen;
        seed     = 32'h5c3;
        clk      = 1'b0;
        reset    <= 1'b1;
        wb_rsp   <= '0;
        ack_wait = -1;
        build_program();
        model_mem = mem;
        foreach (model_x[r]) begin
            model_x[r] = '0;
        end
        model_pc = '0;

        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_value("wb_req.cyc in reset", wb_req.cyc, 1'b0);
            check_value("wb_req.stb in reset", wb_req.stb, 1'b0);
            check_value("wb_req.we in reset", wb_req.we, 1'b0);
            @(posedge clk);
        end
        reset <= 1'b0;
        @(negedge clk);

        while (model_pc != end_pc) begin
            wait_transfer(seen);
            check_value("fetch wb_req.adr", seen.adr, model_pc);
            check_value("fetch wb_req.sel", seen.sel, 4'hf);
            check_value("fetch wb_req.we", seen.we, 1'b0);
            step_model();
            if (exp_mem) begin
                wait_transfer(seen);
                check_value("data wb_req.adr", seen.adr, exp_adr);
                check_value("data wb_req.sel", seen.sel, exp_sel);
                check_value("data wb_req.we", seen.we, exp_we);
                if (exp_we) begin
                    check_value("store wb_req.dat", seen.dat, exp_dat);
                end
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
source/rv_isa_pkg.sv
source/wb_pkg.sv
source/rv_decoder.sv
source/register_file.sv
source/rv_alu.sv
source/wb_master.sv
source/rv_sequencer.sv
source/rv_core.sv
bench/rv_core_tb.sv
